/* src/rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    // srl and sra share this one, funct7 tells them apart
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // sub / sra
    localparam logic [6:0] F7_ALT = 7'b0100000;

    // how execute resolves the operation
    typedef enum logic [1:0] {
        // plain add for addresses, lui and auipc
        ALU_ADD   = 2'd0,
        ALU_RTYPE = 2'd1,
        ALU_ITYPE = 2'd2
    } aluOpT;

    // operand a source
    typedef enum logic [1:0] {
        SRC1_RS1  = 2'd0,
        SRC1_PC   = 2'd1,
        SRC1_ZERO = 2'd2
    } src1T;

    // operand b source
    typedef enum logic [1:0] {
        SRC2_RS2  = 2'd0,
        SRC2_IIMM = 2'd1,
        SRC2_SIMM = 2'd2,
        SRC2_UIMM = 2'd3
    } src2T;

endpackage

`default_nettype wire

/* src/pipePkg.sv */
`default_nettype none

package pipePkg;

    // decoded instruction held in the ID/EX register
    typedef struct packed {
        logic [31:0]        pc;
        rvIsaPkg::src1T     aluSrc1;
        rvIsaPkg::src2T     aluSrc2;
        rvIsaPkg::aluOpT    aluOp;
        // memory stage controls
        logic               memWrite;
        logic               memRead;
        // writeback controls
        logic               regWrite;
        logic               memToReg;
        logic [6:0]         func7;
        logic [2:0]         func3;
        logic [31:0]        read1;
        logic [31:0]        read2;
        logic [31:0]        iImm;
        logic [31:0]        sImm;
        logic [31:0]        uImm;
        logic [4:0]         rd;
        logic [4:0]         rs1;
        logic [4:0]         rs2;
    } idExT;

    // execute result handed on to the memory stage
    typedef struct packed {
        // alu output, doubles as the address for load/store
        logic [31:0]        aluResult;
        logic [31:0]        storeData;
        logic [4:0]         rd;
        logic               regWrite;
        logic               memRead;
        logic               memWrite;
        logic               memToReg;
    } exMemT;

endpackage

`default_nettype wire

/* src/regReadIf.sv */
`timescale 1ns/10ps
`default_nettype none

// two register read ports between decoder and register file
interface regReadIf;

    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] read1;
    logic [31:0] read2;

    modport decoder (output rs1, output rs2, input read1, input read2);

    modport regFile (input rs1, input rs2, output read1, output read2);

endinterface

`default_nettype wire

/* src/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic        wbEn,
    input  logic [4:0]  wbRd,
    input  logic [31:0] wbData,
    regReadIf.regFile   rd
);

    // x1..x31, x0 has no storage
    logic [31:0] regs [31:1];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && (wbRd != 5'd0)) begin
            regs[wbRd] <= wbData;
        end
    end

    // async reads, a write only shows after the edge
    always_comb begin
        rd.read1 = '0;
        rd.read2 = '0;
        if (rd.rs1 != 5'd0) begin
            rd.read1 = regs[rd.rs1];
        end
        if (rd.rs2 != 5'd0) begin
            rd.read2 = regs[rd.rs2];
        end
    end

endmodule

`default_nettype wire

/* src/instrDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instrDecoder (
    input  logic            instrValid,
    input  logic [31:0]     instr,
    input  logic [31:0]     pc,
    output logic            instrReady,
    output logic            outValid,
    input  logic            outReady,
    output pipePkg::idExT   outData,
    regReadIf.decoder       rf
);

    logic [6:0] opcode;
    logic [4:0] rdField;
    logic [4:0] rs1Field;
    logic [4:0] rs2Field;
    logic [2:0] func3Field;
    logic [6:0] func7Field;
    logic [31:0] iImm;
    logic [31:0] sImm;
    logic [31:0] uImm;
    logic supported;

    // no buffering here, the ID/EX stage does the holding
    assign outValid   = instrValid;
    assign instrReady = outReady;

    // fixed field positions
    assign opcode     = instr[6:0];
    assign rdField    = instr[11:7];
    assign func3Field = instr[14:12];
    assign rs1Field   = instr[19:15];
    assign rs2Field   = instr[24:20];
    assign func7Field = instr[31:25];

    // immediates, sign taken from bit 31
    assign iImm = {{20{instr[31]}}, instr[31:20]};
    assign sImm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign uImm = {instr[31:12], 12'b0};

    // unsupported ops read x0 on both ports so the result is zero
    assign rf.rs1 = supported ? rs1Field : 5'd0;
    assign rf.rs2 = supported ? rs2Field : 5'd0;

    always_comb begin
        // defaults cover an unknown opcode: 0 + x0, nothing enabled
        supported        = 1'b1;
        outData.aluSrc1  = rvIsaPkg::SRC1_ZERO;
        outData.aluSrc2  = rvIsaPkg::SRC2_RS2;
        outData.aluOp    = rvIsaPkg::ALU_ADD;
        outData.memWrite = 1'b0;
        outData.memRead  = 1'b0;
        outData.regWrite = 1'b0;
        outData.memToReg = 1'b0;

        case (opcode)
            rvIsaPkg::OPC_OP: begin
                outData.aluSrc1  = rvIsaPkg::SRC1_RS1;
                outData.aluSrc2  = rvIsaPkg::SRC2_RS2;
                outData.aluOp    = rvIsaPkg::ALU_RTYPE;
                outData.regWrite = 1'b1;
            end
            rvIsaPkg::OPC_OPIMM: begin
                outData.aluSrc1  = rvIsaPkg::SRC1_RS1;
                outData.aluSrc2  = rvIsaPkg::SRC2_IIMM;
                outData.aluOp    = rvIsaPkg::ALU_ITYPE;
                outData.regWrite = 1'b1;
            end
            rvIsaPkg::OPC_LUI: begin
                outData.aluSrc1  = rvIsaPkg::SRC1_ZERO;
                outData.aluSrc2  = rvIsaPkg::SRC2_UIMM;
                outData.regWrite = 1'b1;
            end
            rvIsaPkg::OPC_AUIPC: begin
                outData.aluSrc1  = rvIsaPkg::SRC1_PC;
                outData.aluSrc2  = rvIsaPkg::SRC2_UIMM;
                outData.regWrite = 1'b1;
            end
            rvIsaPkg::OPC_LOAD: begin
                // address = rs1 + I imm
                outData.aluSrc1  = rvIsaPkg::SRC1_RS1;
                outData.aluSrc2  = rvIsaPkg::SRC2_IIMM;
                outData.memRead  = 1'b1;
                outData.regWrite = 1'b1;
                outData.memToReg = 1'b1;
            end
            rvIsaPkg::OPC_STORE: begin
                // address = rs1 + S imm, data from rs2
                outData.aluSrc1  = rvIsaPkg::SRC1_RS1;
                outData.aluSrc2  = rvIsaPkg::SRC2_SIMM;
                outData.memWrite = 1'b1;
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    // payload fields that are the same for every opcode
    assign outData.pc    = pc;
    assign outData.func7 = func7Field;
    assign outData.func3 = func3Field;
    assign outData.read1 = rf.read1;
    assign outData.read2 = rf.read2;
    assign outData.iImm  = iImm;
    assign outData.sImm  = sImm;
    assign outData.uImm  = uImm;
    assign outData.rd    = rdField;
    assign outData.rs1   = rf.rs1;
    assign outData.rs2   = rf.rs2;

endmodule

`default_nettype wire

/* src/pipeStageReg.sv */
`timescale 1ns/10ps
`default_nettype none

// one-entry valid/ready register, full throughput
module pipeStageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    input  payloadT inData,
    output logic    inReady,
    output logic    outValid,
    output payloadT outData,
    input  logic    outReady
);

    // can take a new item if empty or draining this cycle
    assign inReady = !outValid || outReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    // payload only moves on a transfer in
    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            outData <= inData;
        end
    end

endmodule

`default_nettype wire

/* src/execUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module execUnit (
    input  pipePkg::idExT  inData,
    output pipePkg::exMemT outData
);

    logic [31:0] opA;
    logic [31:0] opB;
    logic [2:0]  aluFunc;
    logic        altOp;
    logic [4:0]  shamt;
    logic [31:0] result;

    // operand a
    always_comb begin
        case (inData.aluSrc1)
            rvIsaPkg::SRC1_RS1: opA = inData.read1;
            rvIsaPkg::SRC1_PC:  opA = inData.pc;
            default:            opA = '0;
        endcase
    end

    // operand b
    always_comb begin
        case (inData.aluSrc2)
            rvIsaPkg::SRC2_RS2:  opB = inData.read2;
            rvIsaPkg::SRC2_IIMM: opB = inData.iImm;
            rvIsaPkg::SRC2_SIMM: opB = inData.sImm;
            default:             opB = inData.uImm;
        endcase
    end

    // final operation from aluOp, func3, func7
    always_comb begin
        aluFunc = rvIsaPkg::F3_ADD;
        altOp   = 1'b0;
        case (inData.aluOp)
            rvIsaPkg::ALU_RTYPE: begin
                aluFunc = inData.func3;
                altOp   = (inData.func7 == rvIsaPkg::F7_ALT);
            end
            rvIsaPkg::ALU_ITYPE: begin
                // no subi, funct7 only counts for srai
                aluFunc = inData.func3;
                altOp   = (inData.func3 == rvIsaPkg::F3_SR) &&
                          (inData.func7 == rvIsaPkg::F7_ALT);
            end
            default: begin
                aluFunc = rvIsaPkg::F3_ADD;
                altOp   = 1'b0;
            end
        endcase
    end

    // only the low 5 bits shift
    assign shamt = opB[4:0];

    always_comb begin
        case (aluFunc)
            rvIsaPkg::F3_ADD:  result = altOp ? (opA - opB) : (opA + opB);
            rvIsaPkg::F3_SLL:  result = opA << shamt;
            rvIsaPkg::F3_SLT:  result = {31'b0, $signed(opA) < $signed(opB)};
            rvIsaPkg::F3_SLTU: result = {31'b0, opA < opB};
            rvIsaPkg::F3_XOR:  result = opA ^ opB;
            rvIsaPkg::F3_SR:   result = altOp ? 32'($signed(opA) >>> shamt) : (opA >> shamt);
            rvIsaPkg::F3_OR:   result = opA | opB;
            default:           result = opA & opB;
        endcase
    end

    assign outData.aluResult = result;
    // store data always comes from rs2
    assign outData.storeData = inData.read2;
    assign outData.rd        = inData.rd;
    assign outData.regWrite  = inData.regWrite;
    assign outData.memRead   = inData.memRead;
    assign outData.memWrite  = inData.memWrite;
    assign outData.memToReg  = inData.memToReg;

endmodule

`default_nettype wire

/* src/riscvDecodeExecute.sv */
`timescale 1ns/10ps
`default_nettype none

module riscvDecodeExecute (
    input  logic        clk,
    input  logic        rstN,
    // instruction in
    input  logic        instrValid,
    output logic        instrReady,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    // writeback port
    input  logic        wbEn,
    input  logic [4:0]  wbRd,
    input  logic [31:0] wbData,
    // towards memory stage
    output logic        outValid,
    input  logic        outReady,
    output logic [31:0] aluResult,
    output logic [31:0] storeData,
    output logic [4:0]  rd,
    output logic        regWrite,
    output logic        memRead,
    output logic        memWrite,
    output logic        memToReg
);

    regReadIf rfRead ();

    logic           decValid;
    logic           decReady;
    pipePkg::idExT  decData;
    logic           idExValid;
    logic           idExReady;
    pipePkg::idExT  idExData;
    pipePkg::exMemT exData;
    pipePkg::exMemT exMemData;

    regFile uRegFile (
        .clk    (clk),
        .rstN   (rstN),
        .wbEn   (wbEn),
        .wbRd   (wbRd),
        .wbData (wbData),
        .rd     (rfRead.regFile)
    );

    instrDecoder uDecoder (
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .instrReady (instrReady),
        .outValid   (decValid),
        .outReady   (decReady),
        .outData    (decData),
        .rf         (rfRead.decoder)
    );

    // ID/EX
    pipeStageReg #(.payloadT(pipePkg::idExT)) uIdEx (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (decValid),
        .inData   (decData),
        .inReady  (decReady),
        .outValid (idExValid),
        .outData  (idExData),
        .outReady (idExReady)
    );

    execUnit uExec (
        .inData  (idExData),
        .outData (exData)
    );

    // EX/MEM
    pipeStageReg #(.payloadT(pipePkg::exMemT)) uExMem (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (idExValid),
        .inData   (exData),
        .inReady  (idExReady),
        .outValid (outValid),
        .outData  (exMemData),
        .outReady (outReady)
    );

    assign aluResult = exMemData.aluResult;
    assign storeData = exMemData.storeData;
    assign rd        = exMemData.rd;
    assign regWrite  = exMemData.regWrite;
    assign memRead   = exMemData.memRead;
    assign memWrite  = exMemData.memWrite;
    assign memToReg  = exMemData.memToReg;

endmodule

`default_nettype wire

/* dv/clockGen.sv */
`timescale 1ns/10ps
`default_nettype none

// 4 ns clock, reset low for the first two rising edges
module clockGen (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

/* dv/tbDecodeExecute.sv */
`timescale 1ns/10ps
`default_nettype none

module tbDecodeExecute;

    logic        clk;
    logic        rstN;
    logic        instrValid;
    logic        instrReady;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wbEn;
    logic [4:0]  wbRd;
    logic [31:0] wbData;
    logic        outValid;
    logic        outReady;
    logic [31:0] aluResult;
    logic [31:0] storeData;
    logic [4:0]  rd;
    logic        regWrite;
    logic        memRead;
    logic        memWrite;
    logic        memToReg;

    // stimulus and expected values per table row
    string       tName[$];
    logic [31:0] tInstr[$];
    logic [31:0] tPc[$];
    logic [31:0] tRes[$];
    logic [31:0] tStore[$];
    logic [4:0]  tRd[$];
    // {regWrite, memRead, memWrite, memToReg}
    logic [3:0]  tFlags[$];

    logic [31:0] wbVal [0:8];
    logic [31:0] regInit [0:31];
    int          expQ[$];
    int          acceptCount;
    int          outCount;
    int          errorCount;
    int          rowErrors;
    int          idx;
    int          watchdogCycles;
    integer      seed;
    integer      rnd;

    clockGen uClockGen (.clk(clk), .rstN(rstN));

    riscvDecodeExecute u_dut (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .instr      (instr),
        .pc         (pc),
        .wbEn       (wbEn),
        .wbRd       (wbRd),
        .wbData     (wbData),
        .outValid   (outValid),
        .outReady   (outReady),
        .aluResult  (aluResult),
        .storeData  (storeData),
        .rd         (rd),
        .regWrite   (regWrite),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .memToReg   (memToReg)
    );

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rdSel);
        return {f7, rs2, rs1, f3, rdSel, rvIsaPkg::OPC_OP};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rdSel,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rdSel, opc};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        // funct3 010 is sw
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvIsaPkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rdSel,
                                          input logic [6:0] opc);
        return {imm, rdSel, opc};
    endfunction

    task automatic addRow(input string name, input logic [31:0] ins, input logic [31:0] pcVal,
                          input logic [31:0] res, input logic [3:0] flags);
        tName.push_back(name);
        tInstr.push_back(ins);
        tPc.push_back(pcVal);
        tRes.push_back(res);
        tRd.push_back(ins[11:7]);
        tFlags.push_back(flags);
        // storeData is the register named by the rs2 field
        // unsupported ops read x0 instead
        if (flags == 4'b0000) begin
            tStore.push_back(32'h0);
        end else begin
            tStore.push_back(regInit[ins[24:20]]);
        end
    endtask

    task automatic buildTable();
        logic [31:0] p;
        p = 32'h0000_0100;
        addRow("add",      rType(7'h00, 5'd2, 5'd1, rvIsaPkg::F3_ADD, 5'd9),
               p, 32'hFFFF_FFFB, 4'b1000);
        addRow("sub",      rType(7'h20, 5'd2, 5'd1, rvIsaPkg::F3_ADD, 5'd10),
               p, 32'h0000_000F, 4'b1000);
        addRow("sll 33",   rType(7'h00, 5'd3, 5'd1, rvIsaPkg::F3_SLL, 5'd11),
               p, 32'h0000_000A, 4'b1000);
        addRow("slt",      rType(7'h00, 5'd1, 5'd2, rvIsaPkg::F3_SLT, 5'd12),
               p, 32'h0000_0001, 4'b1000);
        addRow("sltu neg", rType(7'h00, 5'd1, 5'd2, rvIsaPkg::F3_SLTU, 5'd13),
               p, 32'h0000_0000, 4'b1000);
        addRow("sltu pos", rType(7'h00, 5'd2, 5'd1, rvIsaPkg::F3_SLTU, 5'd19),
               p, 32'h0000_0001, 4'b1000);
        addRow("xor",      rType(7'h00, 5'd6, 5'd5, rvIsaPkg::F3_XOR, 5'd14),
               p, 32'h1234_5687, 4'b1000);
        addRow("srl",      rType(7'h00, 5'd3, 5'd4, rvIsaPkg::F3_SR, 5'd15),
               p, 32'h4000_0000, 4'b1000);
        addRow("sra",      rType(7'h20, 5'd3, 5'd4, rvIsaPkg::F3_SR, 5'd16),
               p, 32'hC000_0000, 4'b1000);
        addRow("or",       rType(7'h00, 5'd6, 5'd5, rvIsaPkg::F3_OR, 5'd17),
               p, 32'h1234_56FF, 4'b1000);
        addRow("and",      rType(7'h00, 5'd6, 5'd5, rvIsaPkg::F3_AND, 5'd18),
               p, 32'h0000_0078, 4'b1000);
        // negative OP-IMM immediates sign-extend
        addRow("addi neg", iType(12'hFF9, 5'd1, rvIsaPkg::F3_ADD, 5'd21, rvIsaPkg::OPC_OPIMM),
               p, 32'hFFFF_FFFE, 4'b1000);
        addRow("slti",     iType(12'hFFB, 5'd2, rvIsaPkg::F3_SLT, 5'd22, rvIsaPkg::OPC_OPIMM),
               p, 32'h0000_0001, 4'b1000);
        addRow("sltiu",    iType(12'hFFF, 5'd1, rvIsaPkg::F3_SLTU, 5'd23, rvIsaPkg::OPC_OPIMM),
               p, 32'h0000_0001, 4'b1000);
        addRow("xori",     iType(12'hFFF, 5'd6, rvIsaPkg::F3_XOR, 5'd24, rvIsaPkg::OPC_OPIMM),
               p, 32'hFFFF_FF00, 4'b1000);
        addRow("ori",      iType(12'h7F0, 5'd1, rvIsaPkg::F3_OR, 5'd25, rvIsaPkg::OPC_OPIMM),
               p, 32'h0000_07F5, 4'b1000);
        addRow("andi",     iType(12'h0F0, 5'd5, rvIsaPkg::F3_AND, 5'd26, rvIsaPkg::OPC_OPIMM),
               p, 32'h0000_0070, 4'b1000);
        addRow("slli",     iType(12'h004, 5'd1, rvIsaPkg::F3_SLL, 5'd27, rvIsaPkg::OPC_OPIMM),
               p, 32'h0000_0050, 4'b1000);
        addRow("srli",     iType(12'h004, 5'd4, rvIsaPkg::F3_SR, 5'd28, rvIsaPkg::OPC_OPIMM),
               p, 32'h0800_0000, 4'b1000);
        addRow("srai",     iType(12'h404, 5'd4, rvIsaPkg::F3_SR, 5'd29, rvIsaPkg::OPC_OPIMM),
               p, 32'hF800_0000, 4'b1000);
        // funct7 bits set on addi must not turn it into a subtract
        addRow("addi 400", iType(12'h400, 5'd1, rvIsaPkg::F3_ADD, 5'd30, rvIsaPkg::OPC_OPIMM),
               p, 32'h0000_0405, 4'b1000);
        addRow("lui",      uType(20'h12345, 5'd31, rvIsaPkg::OPC_LUI), p, 32'h1234_5000, 4'b1000);
        addRow("auipc",    uType(20'h00001, 5'd9, rvIsaPkg::OPC_AUIPC), 32'h0000_0200,
               32'h0000_1200, 4'b1000);
        addRow("auipc wrap", uType(20'hFFFFF, 5'd10, rvIsaPkg::OPC_AUIPC), 32'h0000_3000,
               32'h0000_2000, 4'b1000);
        addRow("lw",       iType(12'hFFC, 5'd8, 3'b010, 5'd11, rvIsaPkg::OPC_LOAD),
               p, 32'h0000_0FFC, 4'b1101);
        addRow("sw",       sType(12'h008, 5'd5, 5'd8), p, 32'h0000_1008, 4'b0010);
        addRow("sw neg",   sType(12'hFF0, 5'd2, 5'd1), p, 32'hFFFF_FFF5, 4'b0010);
        // x0 was written during preload and must still read zero
        addRow("add x0",   rType(7'h00, 5'd1, 5'd0, rvIsaPkg::F3_ADD, 5'd12), p, 32'h5, 4'b1000);
        addRow("or x0 x0", rType(7'h00, 5'd0, 5'd0, rvIsaPkg::F3_OR, 5'd13), p, 32'h0, 4'b1000);
        addRow("jal",      32'h1234_50EF, p, 32'h0, 4'b0000);
        addRow("beq",      {7'h00, 5'd2, 5'd1, 3'b000, 5'd8, 7'b1100011}, p, 32'h0, 4'b0000);
    endtask

    task automatic checkValue(input int row, input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH time %0t: row %0d (%s) %s got %h expected %h",
                     $time, row, tName[row], what, got, exp);
            rowErrors++;
        end
    endtask

    task automatic preloadRegs();
        for (int r = 0; r < 9; r++) begin
            @(posedge clk);
            wbEn   <= 1'b1;
            wbRd   <= r[4:0];
            wbData <= wbVal[r];
        end
        @(posedge clk);
        wbEn <= 1'b0;
    endtask

    // back-pressure from the memory stage
    always @(posedge clk) begin
        rnd = $random(seed);
        outReady <= rnd[0];
    end

    // handshakes sampled at the falling edge before the transfer edge
    always @(negedge clk) begin
        if (rstN === 1'b1) begin
            if (!instrReady) begin
                assert ((acceptCount - outCount) == 2 && outValid && !outReady) else begin
                    $display("instrReady dropped at %0t while the pipeline was not full", $time);
                    errorCount++;
                end
            end
            if (outValid && outReady) begin
                assert (expQ.size() != 0) else begin
                    $display("unexpected result at %0t with no instruction in flight", $time);
                    errorCount++;
                end
                if (expQ.size() != 0) begin
                    idx = expQ.pop_front();
                    rowErrors = 0;
                    checkValue(idx, "aluResult", aluResult, tRes[idx]);
                    checkValue(idx, "storeData", storeData, tStore[idx]);
                    checkValue(idx, "rd", {27'b0, rd}, {27'b0, tRd[idx]});
                    checkValue(idx, "flags", {28'b0, regWrite, memRead, memWrite, memToReg},
                               {28'b0, tFlags[idx]});
                    $display("row %0d %s: %s", idx, tName[idx], (rowErrors == 0) ? "ok" : "bad");
                    errorCount += rowErrors;
                end
                outCount++;
            end
            if (instrValid && instrReady) begin
                expQ.push_back(acceptCount);
                acceptCount++;
            end
        end
    end

    initial begin
        wait (watchdogCycles != 0);
        repeat (watchdogCycles) @(posedge clk);
        $display("timeout after %0d cycles, the pipeline stopped delivering results",
                 watchdogCycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        instrValid  = 1'b0;
        instr       = 32'h0;
        pc          = 32'h0;
        wbEn        = 1'b0;
        wbRd        = 5'd0;
        wbData      = 32'h0;
        outReady    = 1'b0;
        seed        = 32'h42d2;
        acceptCount = 0;
        outCount    = 0;
        errorCount  = 0;

        // the x0 write has to be ignored
        wbVal = '{32'hDEAD_BEEF, 32'h0000_0005, 32'hFFFF_FFF6, 32'd33, 32'h8000_0000,
                  32'h1234_5678, 32'h0000_00FF, 32'hFFFF_FFFF, 32'h0000_1000};
        for (int r = 0; r < 32; r++) begin
            regInit[r] = (r >= 1 && r <= 8) ? wbVal[r] : 32'h0;
        end
        buildTable();
        watchdogCycles = tName.size() * 20;

        wait (rstN === 1'b1);
        @(negedge clk);
        assert (outValid === 1'b0 && instrReady === 1'b1) else begin
            $display("after reset outValid is %b and instrReady is %b", outValid, instrReady);
            errorCount++;
        end

        preloadRegs();
        for (int i = 0; i < tName.size(); i++) begin
            instrValid <= 1'b1;
            instr      <= tInstr[i];
            pc         <= tPc[i];
            @(negedge clk);
            while (!instrReady) begin
                @(negedge clk);
            end
            @(posedge clk);
        end
        instrValid <= 1'b0;

        while (outCount < tName.size()) begin
            @(posedge clk);
        end
        // let any stray extra result show up
        repeat (6) @(posedge clk);
        assert (expQ.size() == 0 && outCount == tName.size()) else begin
            $display("%0d results seen for %0d rows", outCount, tName.size());
            errorCount++;
        end

        $display("summary: %0d rows, %0d results, %0d errors", tName.size(), outCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
src/rvIsaPkg.sv
src/pipePkg.sv
src/regReadIf.sv
src/regFile.sv
src/instrDecoder.sv
src/pipeStageReg.sv
src/execUnit.sv
src/riscvDecodeExecute.sv
dv/clockGen.sv
dv/tbDecodeExecute.sv
